// ==== Makefile ====
TOP = led_matrix_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --assert -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -j 0 -f all.f \
	    --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q '>>> FAIL' sim.log || ! grep -q '>>> PASS' sim.log; then \
	    echo "simulation failed, see sim.log"; \
	    exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== all.f ====
common/led_matrix_pkg.sv
source/uart_rx.sv
source/frame_ram.sv
control/command_parser.sv
scan/matrix_scan.sv
scan/framebuffer_fetch.sv
source/led_matrix_top.sv
dv/led_matrix_asserts.sv
dv/led_matrix_tb.sv

// ==== common/led_matrix_pkg.sv ====
// ==========================================================
// led matrix shared definitions: widths, pixel layout,
// command codes and scan and uart timing constants
// ==========================================================
package led_matrix_pkg;

    // panel geometry, 64x32 scanned as 16 row pairs
    localparam int NUM_COLS      = 64;
    localparam int NUM_ROW_PAIRS = 16;
    localparam int NUM_PLANES    = 2;

    // timing in clk_root cycles
    localparam int TICKS_PER_BIT = 8;  // per uart bit
    localparam int PIXEL_PERIOD  = 4;  // per shifted column
    localparam int ON_TIME_BASE  = 64; // plane 0 display time, doubles per plane

    typedef logic [5:0] col_addr_t;
    typedef logic [3:0] row_addr_t;    // row r drives panel rows r and r+16

    // stored pixel, bits 1:0 red, 3:2 green, 5:4 blue, 7:6 unused
    typedef logic [7:0] pixel_t;

    typedef logic [2:0] rgb_t;         // bit 0 red, 1 green, 2 blue
    typedef logic       plane_t;
    typedef logic [1:0] plane_mask_t;  // one enable per plane

    // byte address is {row, column, half}, half 0 is top
    typedef logic [10:0] ram_a_addr_t;
    // word address is {row, column}
    typedef logic [9:0]  ram_b_addr_t;
    // top pixel in low byte, bottom pixel in high byte
    typedef logic [15:0] ram_b_data_t;

    // command codes on the serial stream
    localparam pixel_t CMD_PIXEL        = 8'h50; // then x, y, colour
    localparam pixel_t CMD_BRIGHTNESS   = 8'h42; // then plane mask
    localparam pixel_t CMD_COLOR_ENABLE = 8'h43; // then channel mask

endpackage

// ==== control/command_parser.sv ====
// ==========================================================
// command parser, turns received bytes into pixel writes
// and the brightness and colour enable masks
// ==========================================================
module command_parser (
    input  logic                        clk_root,
    input  logic                        arst_n,
    input  led_matrix_pkg::pixel_t      rx_data,
    input  logic                        rx_valid,
    output logic                        wr_en,
    output led_matrix_pkg::ram_a_addr_t wr_addr,
    output led_matrix_pkg::pixel_t      wr_data,
    output led_matrix_pkg::plane_mask_t brightness_enable,
    output led_matrix_pkg::rgb_t        color_enable
);
    import led_matrix_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_PIX_X,
        S_PIX_Y,
        S_PIX_COLOR,
        S_BRIGHTNESS,
        S_COLOR_EN
    } cmd_state_t;

    cmd_state_t state;
    col_addr_t  pix_x;
    row_addr_t  pix_row;
    logic       pix_half;   // y bit 4, bottom half

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            state             <= S_IDLE;
            wr_en             <= 1'b0;
            brightness_enable <= '1;
            color_enable      <= '1;
        end else begin
            wr_en <= 1'b0;
            if (rx_valid) begin
                unique case (state)
                    S_IDLE: begin
                        // anything that is not a command code is dropped
                        case (rx_data)
                            CMD_PIXEL:        state <= S_PIX_X;
                            CMD_BRIGHTNESS:   state <= S_BRIGHTNESS;
                            CMD_COLOR_ENABLE: state <= S_COLOR_EN;
                            default:          state <= S_IDLE;
                        endcase
                    end
                    S_PIX_X: state <= S_PIX_Y;
                    S_PIX_Y: state <= S_PIX_COLOR;
                    S_PIX_COLOR: begin
                        wr_en <= 1'b1;  // write lands the cycle after the byte
                        state <= S_IDLE;
                    end
                    S_BRIGHTNESS: begin
                        brightness_enable <= rx_data[1:0];
                        state             <= S_IDLE;
                    end
                    S_COLOR_EN: begin
                        color_enable <= rx_data[2:0];
                        state        <= S_IDLE;
                    end
                    default: state <= S_IDLE;
                endcase
            end
        end
    end

    // coordinates and write payload
    always_ff @(posedge clk_root) begin
        if (rx_valid && state == S_PIX_X) pix_x <= rx_data[5:0];
        if (rx_valid && state == S_PIX_Y) begin
            pix_row  <= rx_data[3:0];
            pix_half <= rx_data[4];
        end
        if (rx_valid && state == S_PIX_COLOR) begin
            wr_addr <= {pix_row, pix_x, pix_half};
            wr_data <= rx_data;
        end
    end

endmodule

// ==== dv/led_matrix_asserts.sv ====
// ==========================================================
// hub75 protocol checks on the panel control outputs
// ==========================================================
module led_matrix_asserts (
    input logic                      clk_root,
    input logic                      arst_n,
    input logic                      clk_pixel,
    input logic                      row_latch,
    input logic                      output_enable_n,
    input led_matrix_pkg::row_addr_t row_select
);
    timeunit 1ns;
    timeprecision 1ps;

    // no shifting or latching while the row is lit
    quiet_while_lit: assert property (@(posedge clk_root) disable iff (!arst_n)
        !output_enable_n |-> !row_latch && !clk_pixel)
        else $error("row_latch or clk_pixel high while the panel is enabled");

    // lit row must not move under an enabled panel
    row_stable_while_lit: assert property (@(posedge clk_root) disable iff (!arst_n)
        !output_enable_n |=> output_enable_n || $stable(row_select))
        else $error("row_select changed while the panel is enabled");

    single_cycle_latch: assert property (@(posedge clk_root) disable iff (!arst_n)
        row_latch |=> !row_latch)
        else $error("row_latch held for more than one cycle");

endmodule

// ==== dv/led_matrix_tb.sv ====
// ==========================================================
// hub75 driver testbench that sends uart commands and checks
// whole scanned frames against a pixel model
// ==========================================================
module led_matrix_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import led_matrix_pkg::*;

    localparam int NUM_PIXEL_CMDS = 48;
    localparam int NUM_JUNK       = 5;
    localparam int STIM_BYTES     = NUM_PIXEL_CMDS * 4 + 2 + 4 + NUM_JUNK;
    localparam int NUM_CHECKS     = 5;
    localparam int ROW_CYCLES     = NUM_PLANES * (NUM_COLS * PIXEL_PERIOD + 1)
                                    + ON_TIME_BASE * ((1 << NUM_PLANES) - 1);
    localparam int FRAME_CYCLES   = NUM_ROW_PAIRS * ROW_CYCLES;
    // each check can wait up to one frame to line up with row 0
    localparam int TIMEOUT_CYCLES = STIM_BYTES * 10 * TICKS_PER_BIT
                                    + NUM_CHECKS * 2 * FRAME_CYCLES + 2 * FRAME_CYCLES;

    logic      clk_root;
    logic      arst_n;
    logic      uart_rx_line;
    rgb_t      rgb_top;
    rgb_t      rgb_bottom;
    logic      clk_pixel;
    logic      row_latch;
    logic      output_enable_n;
    row_addr_t row_select;

    pixel_t      model [2**$bits(ram_a_addr_t)];
    plane_mask_t model_bright = '1;
    rgb_t        model_color  = '1;
    logic [15:0] lfsr_state   = 16'd35721;

    int check_reqs     = 0;   // written by stimulus only
    int checks_started = 0;
    int frames_done    = 0;
    int unsigned cycle_cnt = 0;

    led_matrix_top UUT (
        .clk_root        (clk_root),
        .arst_n          (arst_n),
        .uart_rx_line    (uart_rx_line),
        .rgb_top         (rgb_top),
        .rgb_bottom      (rgb_bottom),
        .clk_pixel       (clk_pixel),
        .row_latch       (row_latch),
        .output_enable_n (output_enable_n),
        .row_select      (row_select)
    );

    bind led_matrix_top led_matrix_asserts u_led_matrix_asserts (
        .clk_root        (clk_root),
        .arst_n          (arst_n),
        .clk_pixel       (clk_pixel),
        .row_latch       (row_latch),
        .output_enable_n (output_enable_n),
        .row_select      (row_select)
    );

    initial begin
        clk_root = 1'b0;
        forever #50 clk_root = ~clk_root;
    end

    function automatic logic [15:0] galois_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [7:0] random_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[6:0], lfsr_state[0]};
            lfsr_state = galois_next(lfsr_state);
        end
        return v;
    endfunction

    // plane bit of each channel gated by both masks
    function automatic rgb_t expected_bits(input row_addr_t r, input col_addr_t c,
                                           input logic half, input plane_t p);
        pixel_t px;
        rgb_t   bits;
        px = model[{r, c, half}];
        for (int ch = 0; ch < $bits(rgb_t); ch++) begin
            bits[ch] = px[2 * ch + int'(p)] & model_color[ch] & model_bright[p];
        end
        return bits;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("mismatch %s at %0t: got 0x%0h expected 0x%0h", name, $time, got, expected);
            $display(">>> FAIL");
            $fatal(1, "value check failed");
        end
    endtask

    // 8N1 frame sent LSB first from a falling edge
    task automatic send_byte(input pixel_t data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};
        for (int b = 0; b < 10; b++) begin
            uart_rx_line = frame[b];
            repeat (TICKS_PER_BIT) @(negedge clk_root);
        end
    endtask

    task automatic send_pixel(input pixel_t x, input pixel_t y, input pixel_t colour);
        send_byte(CMD_PIXEL);
        send_byte(x);
        send_byte(y);
        send_byte(colour);
        model[{y[3:0], x[5:0], y[4]}] = colour;
    endtask

    task automatic send_mask(input pixel_t cmd, input pixel_t mask);
        send_byte(cmd);
        send_byte(mask);
        if (cmd == CMD_BRIGHTNESS) model_bright = mask[1:0];
        else model_color = mask[2:0];
    endtask

    // let the last write land before asking for one checked frame
    task automatic run_check_frame();
        repeat (2 * TICKS_PER_BIT) @(negedge clk_root);
        check_reqs = check_reqs + 1;
        wait (frames_done == check_reqs);
    endtask

    // scan order is fixed so row and plane follow from the latches
    row_addr_t scan_row      = '0;
    plane_t    scan_plane    = '0;
    plane_t    disp_plane    = '0;
    int        col_cnt       = 0;
    int        oe_low_cnt    = 0;
    int        shifts_left   = 0;
    logic      check_active  = 1'b0;
    rgb_t      top_before    = '0;   // rgb one cycle before the clk_pixel rise
    rgb_t      bottom_before = '0;
    rgb_t      exp_top       = '0;
    rgb_t      exp_bottom    = '0;

    always @(negedge clk_root) begin
        if (arst_n) begin
            if (clk_pixel) begin
                if (check_active) begin
                    exp_top    = expected_bits(scan_row, col_addr_t'(col_cnt), 1'b0, scan_plane);
                    exp_bottom = expected_bits(scan_row, col_addr_t'(col_cnt), 1'b1, scan_plane);
                    check_value("rgb_top at clk_pixel rise", 32'(top_before),
                                32'(exp_top));
                    check_value("rgb_top", 32'(rgb_top), 32'(exp_top));
                    check_value("rgb_bottom at clk_pixel rise", 32'(bottom_before),
                                32'(exp_bottom));
                    check_value("rgb_bottom", 32'(rgb_bottom), 32'(exp_bottom));
                end
                col_cnt = col_cnt + 1;
            end
            if (!output_enable_n) begin
                oe_low_cnt = oe_low_cnt + 1;
            end else if (oe_low_cnt != 0) begin
                check_value("output_enable_n low cycles", 32'(oe_low_cnt),
                            32'(ON_TIME_BASE << disp_plane));
                oe_low_cnt = 0;
            end
            if (row_latch) begin
                check_value("clk_pixel pulses", 32'(col_cnt), 32'(NUM_COLS));
                check_value("row_select", 32'(row_select), 32'(scan_row));
                col_cnt    = 0;
                disp_plane = scan_plane;
                if (check_active) begin
                    shifts_left = shifts_left - 1;
                    if (shifts_left == 0) begin
                        check_active = 1'b0;
                        frames_done  = frames_done + 1;
                    end
                end else if (checks_started < check_reqs && scan_row == '0
                             && scan_plane == '0) begin
                    check_active   = 1'b1;   // next 32 shifts are one full frame
                    shifts_left    = NUM_ROW_PAIRS * NUM_PLANES;
                    checks_started = checks_started + 1;
                end
                if (scan_plane == plane_t'(NUM_PLANES - 1)) begin
                    scan_plane = '0;
                    scan_row   = scan_row + 1'b1;
                end else begin
                    scan_plane = scan_plane + 1'b1;
                end
            end
            top_before    = rgb_top;
            bottom_before = rgb_bottom;
        end
    end

    always @(posedge clk_root) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("timeout: test did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $fatal(1, "timeout");
        end
    end

    initial begin
        pixel_t x_pos;
        pixel_t y_pos;
        pixel_t colour;
        pixel_t junk [NUM_JUNK];
        junk = '{8'h00, 8'hFF, 8'h51, 8'h41, 8'hA5};   // none is a command code
        for (int i = 0; i < $size(model); i++) begin
            model[i] = '0;
        end
        uart_rx_line = 1'b1;
        arst_n       = 1'b0;
        repeat (4) @(negedge clk_root);
        check_value("clk_pixel", 32'(clk_pixel), 32'h0);
        check_value("row_latch", 32'(row_latch), 32'h0);
        check_value("output_enable_n", 32'(output_enable_n), 32'h1);
        check_value("row_select", 32'(row_select), 32'h0);
        check_value("rgb_top", 32'(rgb_top), 32'h0);
        check_value("rgb_bottom", 32'(rgb_bottom), 32'h0);
        arst_n = 1'b1;
        run_check_frame();   // blank ram

        for (int i = 0; i < NUM_PIXEL_CMDS; i++) begin
            x_pos  = random_bits(6);
            y_pos  = random_bits(5);   // bit 4 picks the half
            colour = random_bits(8);
            send_pixel(x_pos, y_pos, colour);
        end
        run_check_frame();

        send_mask(CMD_BRIGHTNESS, 8'h01);   // plane 1 off
        run_check_frame();

        send_mask(CMD_BRIGHTNESS, 8'h03);
        send_mask(CMD_COLOR_ENABLE, 8'h05); // green off
        run_check_frame();

        foreach (junk[i]) begin
            send_byte(junk[i]);
        end
        run_check_frame();

        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== scan/framebuffer_fetch.sv ====
// ==========================================================
// pixel fetch, reads one column word and picks the current
// plane bit of each channel for both halves, then masks it
// ==========================================================
module framebuffer_fetch (
    input  logic                        clk_root,
    input  logic                        arst_n,
    input  led_matrix_pkg::col_addr_t   column,
    input  led_matrix_pkg::row_addr_t   row,
    input  led_matrix_pkg::plane_t      plane,
    output led_matrix_pkg::ram_b_addr_t rd_addr,
    input  led_matrix_pkg::ram_b_data_t rd_data,
    input  led_matrix_pkg::plane_mask_t brightness_enable,
    input  led_matrix_pkg::rgb_t        color_enable,
    output led_matrix_pkg::rgb_t        rgb_top,
    output led_matrix_pkg::rgb_t        rgb_bottom
);
    import led_matrix_pkg::*;

    plane_t plane_q;    // travels with the ram read
    pixel_t pix_top;
    pixel_t pix_bottom;
    rgb_t   bits_top;
    rgb_t   bits_bottom;
    rgb_t   enable;

    // the ram's registered read port holds the address
    assign rd_addr = {row, column};

    assign pix_top    = rd_data[7:0];
    assign pix_bottom = rd_data[15:8];

    // two bits per channel, plane selects which
    always_comb begin
        for (int c = 0; c < $bits(rgb_t); c++) begin
            bits_top[c]    = pix_top[2 * c + int'(plane_q)];
            bits_bottom[c] = pix_bottom[2 * c + int'(plane_q)];
        end
    end

    assign enable = color_enable & {$bits(rgb_t){brightness_enable[plane_q]}};

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            plane_q    <= '0;
            rgb_top    <= '0;
            rgb_bottom <= '0;
        end else begin
            plane_q    <= plane;
            rgb_top    <= bits_top & enable;
            rgb_bottom <= bits_bottom & enable;
        end
    end

endmodule

// ==== scan/matrix_scan.sv ====
// ==========================================================
// panel scan sequencer, per row pair and plane: shift 64
// columns, latch the row, then light it for a weighted time
// ==========================================================
module matrix_scan (
    input  logic                      clk_root,
    input  logic                      arst_n,
    output led_matrix_pkg::col_addr_t column,
    output led_matrix_pkg::row_addr_t row,
    output led_matrix_pkg::plane_t    plane,
    output logic                      clk_pixel,
    output logic                      row_latch,
    output logic                      output_enable_n,
    output led_matrix_pkg::row_addr_t row_select
);
    import led_matrix_pkg::*;

    typedef logic [$clog2(PIXEL_PERIOD)-1:0] phase_t;
    typedef logic [$clog2(ON_TIME_BASE << (NUM_PLANES - 1))-1:0] disp_cnt_t;
    typedef enum logic [1:0] {ST_SHIFT, ST_LATCH, ST_DISPLAY} scan_state_t;

    scan_state_t state;
    phase_t      phase;
    disp_cnt_t   disp_cnt;
    logic        pix_start;
    logic [1:0]  pix_pipe;  // matches the two cycle fetch latency

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            state           <= ST_SHIFT;
            phase           <= '0;
            column          <= '0;
            disp_cnt        <= '0;
            row             <= '0;
            plane           <= '0;
            row_latch       <= 1'b0;
            output_enable_n <= 1'b1;
            row_select      <= '0;
        end else begin
            row_latch <= 1'b0;
            unique case (state)
                ST_SHIFT: begin
                    if (phase == phase_t'(PIXEL_PERIOD - 1)) begin
                        phase  <= '0;
                        column <= column + 1'b1; // wraps back to 0 after the last one
                        if (column == col_addr_t'(NUM_COLS - 1)) begin
                            state      <= ST_LATCH;
                            row_latch  <= 1'b1;
                            row_select <= row;   // only place the lit row moves
                        end
                    end else begin
                        phase <= phase + 1'b1;
                    end
                end
                ST_LATCH: begin
                    state           <= ST_DISPLAY;
                    output_enable_n <= 1'b0;
                    disp_cnt        <= disp_cnt_t'((ON_TIME_BASE << plane) - 1);
                end
                ST_DISPLAY: begin
                    if (disp_cnt == '0) begin
                        state           <= ST_SHIFT;
                        output_enable_n <= 1'b1;
                        if (plane == plane_t'(NUM_PLANES - 1)) begin
                            plane <= '0;
                            row   <= row + 1'b1;   // 15 wraps to 0
                        end else begin
                            plane <= plane + 1'b1;
                        end
                    end else begin
                        disp_cnt <= disp_cnt - 1'b1;
                    end
                end
                default: state <= ST_SHIFT;
            endcase
        end
    end

    // raw pulse at phase 1, shows up at phase 3 with the fetched data
    // already stable for a cycle
    assign pix_start = (state == ST_SHIFT) && (phase == phase_t'(1));

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            pix_pipe <= '0;
        end else begin
            pix_pipe <= {pix_pipe[0], pix_start};
        end
    end

    assign clk_pixel = pix_pipe[1];

endmodule

// ==== source/frame_ram.sv ====
// ==========================================================
// frame ram, 2048 pixel bytes, byte write port and
// two-byte read port with one cycle of read latency
// ==========================================================
module frame_ram (
    input  logic                        clk_root,
    input  logic                        wr_en,
    input  led_matrix_pkg::ram_a_addr_t wr_addr,
    input  led_matrix_pkg::pixel_t      wr_data,
    input  led_matrix_pkg::ram_b_addr_t rd_addr,
    output led_matrix_pkg::ram_b_data_t rd_data
);
    import led_matrix_pkg::*;

    pixel_t mem [2**$bits(ram_a_addr_t)];

    // blank panel at configuration
    initial begin
        for (int i = 0; i < 2**$bits(ram_a_addr_t); i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk_root) begin
        if (wr_en) mem[wr_addr] <= wr_data;
    end

    // both halves of one column, bottom in high byte
    always_ff @(posedge clk_root) begin
        rd_data <= {mem[{rd_addr, 1'b1}], mem[{rd_addr, 1'b0}]};
    end

endmodule

// ==== source/led_matrix_top.sv ====
// ==========================================================
// hub75 driver top, 64x32 panel fed from a uart command
// stream through a dual-port frame ram
// ==========================================================
module led_matrix_top (
    input  logic                      clk_root,
    input  logic                      arst_n,
    input  logic                      uart_rx_line,
    output led_matrix_pkg::rgb_t      rgb_top,
    output led_matrix_pkg::rgb_t      rgb_bottom,
    output logic                      clk_pixel,
    output logic                      row_latch,
    output logic                      output_enable_n,
    output led_matrix_pkg::row_addr_t row_select
);
    import led_matrix_pkg::*;

    pixel_t      rx_data;
    logic        rx_valid;
    logic        wr_en;
    ram_a_addr_t wr_addr;
    pixel_t      wr_data;
    plane_mask_t brightness_enable;
    rgb_t        color_enable;
    col_addr_t   column;
    row_addr_t   row;
    plane_t      plane;
    ram_b_addr_t rd_addr;
    ram_b_data_t rd_data;

    uart_rx u_uart_rx (
        .clk_root (clk_root),
        .arst_n   (arst_n),
        .rx_line  (uart_rx_line),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    command_parser u_command_parser (
        .clk_root          (clk_root),
        .arst_n            (arst_n),
        .rx_data           (rx_data),
        .rx_valid          (rx_valid),
        .wr_en             (wr_en),
        .wr_addr           (wr_addr),
        .wr_data           (wr_data),
        .brightness_enable (brightness_enable),
        .color_enable      (color_enable)
    );

    frame_ram u_frame_ram (
        .clk_root (clk_root),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    matrix_scan u_matrix_scan (
        .clk_root        (clk_root),
        .arst_n          (arst_n),
        .column          (column),
        .row             (row),
        .plane           (plane),
        .clk_pixel       (clk_pixel),
        .row_latch       (row_latch),
        .output_enable_n (output_enable_n),
        .row_select      (row_select)
    );

    framebuffer_fetch u_framebuffer_fetch (
        .clk_root          (clk_root),
        .arst_n            (arst_n),
        .column            (column),
        .row               (row),
        .plane             (plane),
        .rd_addr           (rd_addr),
        .rd_data           (rd_data),
        .brightness_enable (brightness_enable),
        .color_enable      (color_enable),
        .rgb_top           (rgb_top),
        .rgb_bottom        (rgb_bottom)
    );

endmodule

// ==== source/uart_rx.sv ====
// ==========================================================
// uart receiver, 8N1 LSB first, with a two-flop input
// synchronizer and a one-cycle strobe per good byte
// ==========================================================
module uart_rx (
    input  logic                  clk_root,
    input  logic                  arst_n,
    input  logic                  rx_line,
    output led_matrix_pkg::pixel_t rx_data,
    output logic                  rx_valid
);
    import led_matrix_pkg::*;

    typedef logic [$clog2(TICKS_PER_BIT)-1:0] tick_t;
    typedef enum logic [1:0] {ST_IDLE, ST_START, ST_DATA, ST_STOP} rx_state_t;

    rx_state_t  state;
    logic [1:0] sync_q;     // line idles high
    logic       rx_s;
    tick_t      tick_cnt;
    logic [2:0] bit_idx;
    pixel_t     shift_q;
    logic       sample;

    assign rx_s = sync_q[1];
    assign sample = (tick_cnt == tick_t'(TICKS_PER_BIT - 1)); // middle of data/stop bit

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            sync_q   <= 2'b11;
            state    <= ST_IDLE;
            tick_cnt <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            sync_q   <= {sync_q[0], rx_line};
            rx_valid <= 1'b0;
            tick_cnt <= tick_cnt + 1'b1;
            unique case (state)
                ST_IDLE: begin
                    tick_cnt <= '0;
                    if (!rx_s) state <= ST_START;
                end
                ST_START: begin
                    // half a bit in, check start is still low
                    if (tick_cnt == tick_t'(TICKS_PER_BIT / 2 - 1)) begin
                        tick_cnt <= '0;
                        bit_idx  <= '0;
                        state    <= rx_s ? ST_IDLE : ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (sample) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= ST_STOP;
                    end
                end
                ST_STOP: begin
                    if (sample) begin
                        rx_valid <= rx_s; // low stop bit drops the byte
                        state    <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_root) begin
        if (state == ST_DATA && sample) shift_q <= {rx_s, shift_q[7:1]};
        if (state == ST_STOP && sample) rx_data <= shift_q;
    end

endmodule
